// File: source/f2d_pkg.sv
package f2d_pkg;

    // #########################################################################
    // field widths and exponent limits
    // #########################################################################

    localparam int word_w = 32;
    localparam int exp_w = 8;
    localparam int man_w = 23;
    localparam int exp_bias = 127;
    localparam int exp_int_max = 23;           // widest integer part still exact.
    localparam int exp_frac_min = -16;         // smallest exponent with a usable fraction.

    localparam int lead_digits = 6;            // thresholds 10^8 down to 10^3.

    // #########################################################################
    // decimal types
    // #########################################################################

    typedef logic [word_w-1:0] ieee_word_t;
    typedef logic signed [exp_w-1:0] exp_t;
    typedef logic [man_w-1:0] frac_bits_t;     // msb carries weight 1/2.
    typedef logic [31:0] dec_t;
    typedef logic [1:0] cvt_level_t;
    typedef logic [2:0] lead0_t;

    localparam dec_t frac_scale = 32'd1_000_000_000;

    // #########################################################################
    // fraction weights
    // #########################################################################

    // Decimal weight of fraction bit rank k, that is 10^9 / 2^k truncated.
    function automatic dec_t frac_weight(input int k);
        dec_t weight;
        weight = frac_scale >> k;
        return weight;
    endfunction

endpackage

// File: source/f2d_fields_if.sv
interface f2d_fields_if;
    import f2d_pkg::*;

    dec_t int_part;                             // aligned integer part.
    frac_bits_t frac_bits;                      // aligned fraction, msb is 1/2.
    logic overflow;                             // exponent outside the accepted range.
    logic is_zero;                              // input word is all zeros.

    modport unpack (
        output int_part,
        output frac_bits,
        output overflow,
        output is_zero
    );

    modport tree (
        input frac_bits
    );

    modport result (
        input int_part,
        input is_zero,
        input overflow
    );

endinterface

// File: source/ieee754_unpack.sv
module ieee754_unpack (
    input  f2d_pkg::ieee_word_t value_754,
    f2d_fields_if.unpack        fields
);
    import f2d_pkg::*;

    logic [exp_w-1:0] exp_raw;
    logic [man_w:0] mantissa;
    exp_t exp_val;
    logic [exp_w-1:0] neg_shift;
    logic [2*man_w:0] left_shifted;
    logic [man_w:0] right_shifted;

    // #########################################################################
    // field split and bias removal
    // #########################################################################

    assign exp_raw = value_754[word_w-2 -: exp_w];
    assign mantissa = {1'b1, value_754[man_w-1:0]};   // hidden one restored.
    assign exp_val = exp_t'(exp_raw - exp_w'(exp_bias));

    assign fields.overflow = (int'(exp_val) > exp_int_max) ||
                             (int'(exp_val) < exp_frac_min);
    assign fields.is_zero = (value_754 == '0);

    // #########################################################################
    // alignment
    // #########################################################################

    // integer bits end up above bit man_w, fraction bits below it.
    assign left_shifted = {{man_w{1'b0}}, mantissa} << exp_val;

    assign neg_shift = -exp_val;
    assign right_shifted = mantissa >> neg_shift;      // the hidden one moves below 1/2.

    always_comb begin
        if (exp_val[exp_w-1]) begin
            fields.int_part = '0;                      // the value is below one.
            fields.frac_bits = right_shifted[man_w-1:0];
        end else begin
            fields.int_part = dec_t'(left_shifted[2*man_w:man_w]);
            fields.frac_bits = left_shifted[man_w-1:0];
        end
    end

endmodule

// File: source/adder_tree_level.sv
module adder_tree_level #(
    parameter int n_in = 2,
    parameter int n_out = 1
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load,
    input  f2d_pkg::dec_t [n_in-1:0]      sums_in,
    output f2d_pkg::dec_t [n_out-1:0]     sums_out
);
    import f2d_pkg::*;

    dec_t [n_out-1:0] sums_next;

    // Inputs are summed in pairs, and any leftovers fold into the last output.
    always_comb begin
        sums_next = '0;
        for (int i = 0; i < n_in; i++) begin
            if (i / 2 < n_out) begin
                sums_next[i/2] = sums_next[i/2] + sums_in[i];
            end else begin
                sums_next[n_out-1] = sums_next[n_out-1] + sums_in[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sums_out <= '0;
        end else if (load) begin
            sums_out <= sums_next;                     // otherwise the old sums are held.
        end
    end

endmodule

// File: source/frac_weight_tree.sv
module frac_weight_tree (
    input  logic                clk,
    input  logic                rst,
    input  f2d_pkg::cvt_level_t cvt_cnt,
    f2d_fields_if.tree          fields,
    output f2d_pkg::dec_t       fraction_raw
);
    import f2d_pkg::*;

    localparam int lv0_n = 11;
    localparam int lv1_n = 6;
    localparam int lv2_n = 3;

    dec_t [man_w-1:0] terms;
    dec_t [lv0_n-1:0] lv0_sums;
    dec_t [lv1_n-1:0] lv1_sums;
    dec_t [lv2_n-1:0] lv2_sums;
    logic [3:0] level_load;

    // #########################################################################
    // weight gating
    // #########################################################################

    // term i belongs to bit rank i+1, so the 1/2 weight comes first.
    always_comb begin
        for (int k = 1; k <= man_w; k++) begin
            terms[k-1] = fields.frac_bits[man_w-k] ? frac_weight(k) : '0;
        end
    end

    always_comb begin
        level_load = '0;
        level_load[cvt_cnt] = 1'b1;                   // one level per counter value.
    end

    // #########################################################################
    // adder tree levels
    // #########################################################################

    adder_tree_level #(.n_in(man_w), .n_out(lv0_n)) u_level0 (
        .clk      (clk),
        .rst      (rst),
        .load     (level_load[0]),
        .sums_in  (terms),
        .sums_out (lv0_sums)
    );

    adder_tree_level #(.n_in(lv0_n), .n_out(lv1_n)) u_level1 (
        .clk      (clk),
        .rst      (rst),
        .load     (level_load[1]),
        .sums_in  (lv0_sums),
        .sums_out (lv1_sums)
    );

    adder_tree_level #(.n_in(lv1_n), .n_out(lv2_n)) u_level2 (
        .clk      (clk),
        .rst      (rst),
        .load     (level_load[2]),
        .sums_in  (lv1_sums),
        .sums_out (lv2_sums)
    );

    adder_tree_level #(.n_in(lv2_n), .n_out(1)) u_level3 (
        .clk      (clk),
        .rst      (rst),
        .load     (level_load[3]),
        .sums_in  (lv2_sums),
        .sums_out (fraction_raw)
    );

endmodule

// File: source/dec_output.sv
module dec_output (
    f2d_fields_if.result     fields,
    input  f2d_pkg::dec_t    fraction_raw,
    output f2d_pkg::dec_t    int_dec,
    output f2d_pkg::dec_t    fraction_dec,
    output f2d_pkg::lead0_t  lead0_num,
    output logic             overflow
);
    import f2d_pkg::*;

    localparam dec_t lead_thr [lead_digits] = '{
        32'd100_000_000,
        32'd10_000_000,
        32'd1_000_000,
        32'd100_000,
        32'd10_000,
        32'd1_000
    };

    // a zero word would otherwise decode as 2^-127 with a hidden one.
    assign int_dec = fields.is_zero ? '0 : fields.int_part;
    assign fraction_dec = fields.is_zero ? '0 : fraction_raw;
    assign overflow = fields.overflow;

    // The thresholds are nested, so counting them gives the leading zeros.
    always_comb begin
        lead0_num = '0;
        for (int d = 0; d < lead_digits; d++) begin
            if (fraction_dec < lead_thr[d]) begin
                lead0_num = lead0_num + lead0_t'(1);
            end
        end
    end

endmodule

// File: source/float_to_dec.sv
module float_to_dec (
    input  logic                clk,
    input  logic                rst,
    input  f2d_pkg::ieee_word_t value_754,
    input  f2d_pkg::cvt_level_t cvt_cnt,
    output f2d_pkg::dec_t       int_dec,
    output f2d_pkg::dec_t       fraction_dec,
    output f2d_pkg::lead0_t     lead0_num,
    output logic                overflow
);
    import f2d_pkg::*;

    dec_t fraction_raw;                               // level 3 sum before masking.

    f2d_fields_if fields ();

    ieee754_unpack u_unpack (
        .value_754 (value_754),
        .fields    (fields.unpack)
    );

    frac_weight_tree u_tree (
        .clk          (clk),
        .rst          (rst),
        .cvt_cnt      (cvt_cnt),
        .fields       (fields.tree),
        .fraction_raw (fraction_raw)
    );

    dec_output u_output (
        .fields       (fields.result),
        .fraction_raw (fraction_raw),
        .int_dec      (int_dec),
        .fraction_dec (fraction_dec),
        .lead0_num    (lead0_num),
        .overflow     (overflow)
    );

endmodule

// File: tb/float_to_dec_assertions.sv
module float_to_dec_assertions (
    input logic                clk,
    input logic                rst,
    input f2d_pkg::ieee_word_t value_754,
    input f2d_pkg::dec_t       int_dec,
    input f2d_pkg::dec_t       fraction_dec,
    input f2d_pkg::lead0_t     lead0_num
);
    timeunit 1ns;
    timeprecision 1ps;
    import f2d_pkg::*;

    int unsigned failures = 0;

    // six only when the fraction is below the smallest threshold.
    lead0_in_range: assert property (@(posedge clk) disable iff (rst)
        (lead0_num <= lead0_t'(lead_digits)) &&
        ((lead0_num == lead0_t'(lead_digits)) == (fraction_dec < 32'd1_000)))
        else begin
            failures++;
            $error("lead0_num is out of range or disagrees with a fraction below 1000");
        end

    zero_word_gives_zero_result: assert property (@(posedge clk) disable iff (rst)
        value_754 == '0 |-> int_dec == '0 && fraction_dec == '0)
        else begin
            failures++;
            $error("int_dec or fraction_dec is not zero for an all zero input word");
        end

    // the tree registers are cleared, so nothing can reach the output yet.
    fraction_clear_after_reset: assert property (@(posedge clk)
        rst |=> fraction_dec == '0)
        else begin
            failures++;
            $error("fraction_dec is not zero in the cycle after reset");
        end

endmodule

bind float_to_dec float_to_dec_assertions u_assertions (
    .clk          (clk),
    .rst          (rst),
    .value_754    (value_754),
    .int_dec      (int_dec),
    .fraction_dec (fraction_dec),
    .lead0_num    (lead0_num)
);

// File: tb/tb_float_to_dec.sv
module tb_float_to_dec;
    timeunit 1ns;
    timeprecision 1ps;
    import f2d_pkg::*;

    localparam int max_vectors = 64;
    localparam int vec_cols = 5;                       // word, int, fraction, lead0, overflow.
    localparam int cycles_per_vector = 6;
    localparam int cycle_limit = cycles_per_vector * max_vectors + 20;

    logic clk;
    logic rst;
    ieee_word_t value_754;
    cvt_level_t cvt_cnt;
    dec_t int_dec;
    dec_t fraction_dec;
    lead0_t lead0_num;
    logic overflow;

    logic [31:0] golden [1 + vec_cols * max_vectors];  // entry 0 holds the vector count.
    int n_vectors;
    int vec_idx;
    int cycles = 0;

    float_to_dec UUT (
        .clk          (clk),
        .rst          (rst),
        .value_754    (value_754),
        .cvt_cnt      (cvt_cnt),
        .int_dec      (int_dec),
        .fraction_dec (fraction_dec),
        .lead0_num    (lead0_num),
        .overflow     (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ########################################################################
    // result checks
    // ########################################################################

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_dec(input string name, input dec_t got, input dec_t expected);
        if (got !== expected) begin
            report_failure($sformatf("mismatch %s (vector %0d): got 0x%08h, expected 0x%08h",
                                     name, vec_idx, got, expected));
        end
    endtask

    task automatic check_lead0(input string name, input lead0_t got, input lead0_t expected);
        if (got !== expected) begin
            report_failure($sformatf("mismatch %s (vector %0d): got 0x%01h, expected 0x%01h",
                                     name, vec_idx, got, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            report_failure($sformatf("mismatch %s (vector %0d): got 0x%01h, expected 0x%01h",
                                     name, vec_idx, got, expected));
        end
    endtask

    // Steps the level counter 0 to 3 and returns half a cycle after the level 3 load.
    task automatic run_conversion(input ieee_word_t word);
        @(posedge clk);
        value_754 <= word;
        for (int lvl = 0; lvl < 4; lvl++) begin
            cvt_cnt <= cvt_level_t'(lvl);
            @(posedge clk);                            // level lvl loads on this edge.
        end
        @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            report_failure($sformatf("timeout: the run went past %0d clock cycles",
                                     cycle_limit));
        end
    end

    // ########################################################################
    // main sequence
    // ########################################################################

    initial begin
        int base;
        logic exp_ovf;

        value_754 = 32'h3fc0_0000;                     // nonzero, so the zero mask stays off.
        cvt_cnt = '0;
        rst = 1'b1;

        $readmemh("tb/golden_vectors.txt", golden);
        n_vectors = int'(golden[0]);
        if (n_vectors < 1 || n_vectors > max_vectors) begin
            report_failure("the golden vector file is missing or gives a bad vector count");
        end

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // vector 0 stands for the state right after reset.
        vec_idx = 0;
        @(negedge clk);
        check_dec("fraction_dec", fraction_dec, '0);
        check_lead0("lead0_num", lead0_num, lead0_t'(lead_digits));

        for (vec_idx = 1; vec_idx <= n_vectors; vec_idx++) begin
            base = 1 + vec_cols * (vec_idx - 1);
            exp_ovf = golden[base + 4][0];
            run_conversion(golden[base]);
            check_flag("overflow", overflow, exp_ovf);
            // out of range words carry no defined result, except the all zero word.
            if (!exp_ovf || golden[base] == '0) begin
                check_dec("int_dec", int_dec, golden[base + 1]);
                check_dec("fraction_dec", fraction_dec, golden[base + 2]);
                check_lead0("lead0_num", lead0_num, lead0_t'(golden[base + 3]));
            end
        end

        if (UUT.u_assertions.failures != 0) begin
            report_failure($sformatf("%0d bound assertion checks failed",
                                     UUT.u_assertions.failures));
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// File: tb/golden_vectors.txt
// first value: number of vectors that follow, in hex
// columns: input word, int_dec, fraction_dec (x 10^9), lead0_num, overflow
19
3fc00000 00000001 1dcd6500 0 0  // 1.5
bfc00000 00000001 1dcd6500 0 0  // -1.5, the sign is ignored
40500000 00000003 0ee6b280 0 0  // 3.25
42c98000 00000064 2cb41780 0 0  // 100.75
47800020 00010000 0ee6b280 0 0  // 65536.25
4affffff 007fffff 1dcd6500 0 0  // 8388607.5
4b7fffff 00ffffff 00000000 6 0  // 16777215
4b000000 00800000 00000000 6 0  // 2^23
3f800000 00000001 00000000 6 0  // 1.0
3f000000 00000000 1dcd6500 0 0  // 0.5
3ec00000 00000000 165a0bc0 0 0  // 0.375
3f7fffff 00000000 3b9ac982 0 0  // largest value below one
3dcccccd 00000000 05f5e09d 1 0  // 0.1
3d4ccccd 00000000 02faf04d 1 0  // 0.05
3f810000 00000001 00773594 2 0  // 1 + 2^-7
3f802000 00000001 000ee6b2 3 0  // 1 + 2^-10
3f800200 00000001 0000ee6b 4 0  // 1 + 2^-14
37800000 00000000 00003b9a 4 0  // 2^-16
3f800040 00000001 00001dcd 5 0  // 1 + 2^-17
3f800008 00000001 000003b9 6 0  // 1 + 2^-20, about 0.000001
00000000 00000000 00000000 6 1  // all zero word
4b800000 00000000 00000000 0 1  // 2^24, only overflow is checked
37000000 00000000 00000000 0 1  // 2^-17, only overflow is checked
358637bd 00000000 00000000 0 1  // 0.000001, only overflow is checked
7f800000 00000000 00000000 0 1  // infinity, only overflow is checked

// File: tb.f
source/f2d_pkg.sv
source/f2d_fields_if.sv
source/ieee754_unpack.sv
source/adder_tree_level.sv
source/frac_weight_tree.sv
source/dec_output.sv
source/float_to_dec.sv
tb/float_to_dec_assertions.sv
tb/tb_float_to_dec.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_float_to_dec
FILE_LIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Verification passed
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
